//--- flitRouter.f
flitPkg.sv
routerPkg.sv
flitLoader.sv
flitQueue.sv
packetTimer.sv
portArbiter.sv
flitSender.sv
flitRouter.sv
flitRouter_assert.sv
flitRouter_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the flitRouter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module flitRouter_tb -f flitRouter.f; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/VflitRouter_tb +verilator+error+limit+100 2>&1)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- flitRouter_tb.sv
`timescale 1ns/100ps
`default_nettype none

module flitRouter_tb;

  import flitPkg::*;
  import routerPkg::*;

  localparam int timeoutCycles = 300;

  logic clk;
  logic rst;
  logic inCyc;
  logic inStb;
  logic inWe;
  logic [portAdrWidth-1:0] inAdr;
  flitT inDat;
  logic inAck;
  logic outCyc;
  logic outStb;
  logic outWe;
  logic [portAdrWidth-1:0] outAdr;
  flitT outDat;
  logic outAck;

  flitT expQ [numPorts][$];   // Flits still owed, per port.
  int hdrOrder [$];           // Expected header ports, round-robin test only.
  int pktRemaining;
  int pktPort;
  logic holdOutput;           // Sink withholds outAck.
  string testName;

  flitRouter flitRouter_inst (
    .clk    (clk),
    .rst    (rst),
    .inCyc  (inCyc),
    .inStb  (inStb),
    .inWe   (inWe),
    .inAdr  (inAdr),
    .inDat  (inDat),
    .inAck  (inAck),
    .outCyc (outCyc),
    .outStb (outStb),
    .outWe  (outWe),
    .outAdr (outAdr),
    .outDat (outDat),
    .outAck (outAck)
  );

  always #50 clk = ~clk;

  function automatic flitT headerFlit(input int len);
    flitT f;
    f.hdr.id = idHeader;
    f.hdr.length = lengthWidth'(len);
    f.hdr.spare = 1'b0;
    return f;
  endfunction

  function automatic flitT bodyFlit(input int payload);
    flitT f;
    f.body.id = idBody;
    f.body.payload = (flitWidth-flitIdWidth)'(payload);
    return f;
  endfunction

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input bus master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic writeFlit(input int adr, input flitT data);
    int waited;
    if (adr < numPorts)
    begin
      expQ[adr].push_back(data);   // Out-of-range writes are never owed.
    end
    inCyc = 1'b1;
    inStb = 1'b1;
    inWe = 1'b1;
    inAdr = portAdrWidth'(adr);
    inDat = data;
    waited = 0;
    do
    begin
      @(posedge clk);
      #10;
      waited++;
      assert (waited < timeoutCycles)
        else reportFailure($sformatf("No ack for write to address %0d in %s", adr, testName));
    end
    while (!inAck);
    @(posedge clk);   // Edge that completes the transfer.
    #10;
    inCyc = 1'b0;
    inStb = 1'b0;
  endtask

  task automatic sendPacket(input int port, input int len, input int base);
    writeFlit(port, headerFlit(len));
    for (int i = 0; i < len; i++)
    begin
      writeFlit(port, bodyFlit(base + i));
    end
  endtask

  task automatic waitDrain();
    int waited;
    int pending;
    waited = 0;
    do
    begin
      @(posedge clk);
      #10;
      waited++;
      pending = 0;
      for (int p = 0; p < numPorts; p++)
      begin
        pending += expQ[p].size();
      end
      assert (waited < timeoutCycles)
        else reportFailure($sformatf("Output did not drain in %s", testName));
    end
    while (pending != 0 || outCyc);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output sink and scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic checkTransfer();
    flitT expected;
    int port;
    int expPort;
    port = int'(outAdr);
    assert (outWe)
      else reportFailure($sformatf("Mismatch %s outWe expected 1 actual %b", testName, outWe));
    assert (outDat.body.id != 3'd7)
      else reportFailure("Flit written to address 6 reached the output");
    assert (port < numPorts && expQ[port].size() != 0)
      else reportFailure($sformatf("Unexpected flit %h on port %0d in %s", outDat, port, testName));
    expected = expQ[port].pop_front();
    assert (outDat == expected)
      else reportFailure($sformatf("Mismatch %s flit expected %h actual %h", testName, expected,
                                   outDat));
    if (pktRemaining > 0)
    begin
      assert (port == pktPort)
        else reportFailure($sformatf("Mismatch %s packet port expected %0d actual %0d", testName,
                                     pktPort, port));
      pktRemaining--;
    end
    else if (outDat.hdr.id == idHeader)
    begin
      pktRemaining = int'(outDat.hdr.length);
      pktPort = port;
      if (hdrOrder.size() != 0)
      begin
        expPort = hdrOrder.pop_front();
        assert (port == expPort)
          else reportFailure($sformatf("Mismatch %s header port expected %0d actual %0d",
                                       testName, expPort, port));
      end
    end
  endtask

  always @(negedge clk)
  begin
    assert (flitRouter_inst.flitRouter_assert_inst.failCount == 0)
      else reportFailure("A bus assertion on the DUT ports failed");
    if (!rst && outStb && outAck)
    begin
      checkTransfer();
    end
  end

  initial
  begin
    int delay;
    void'($urandom(32'hb1262662));
    forever
    begin
      @(posedge clk);
      #10;
      outAck = 1'b0;
      if (outStb && !holdOutput)
      begin
        delay = $urandom % 4;
        repeat (delay)
        begin
          @(posedge clk);
          #10;
        end
        outAck = 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    int rrPort;
    clk = 1'b0;
    rst = 1'b1;
    inCyc = 1'b0;
    inStb = 1'b0;
    inWe = 1'b0;
    inAdr = '0;
    inDat = '0;
    outAck = 1'b0;
    holdOutput = 1'b0;
    pktRemaining = 0;
    pktPort = 0;
    testName = "reset";
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;

    testName = "portOrder";
    sendPacket(portL, 2, 16);
    sendPacket(portE, 3, 32);
    sendPacket(portS, 0, 0);   // Header only.
    sendPacket(portL, 1, 48);
    sendPacket(portW, 2, 64);
    sendPacket(portN, 1, 80);
    waitDrain();

    // All five loaded behind a stalled W header, so the rotation wraps past S.
    testName = "roundRobin";
    holdOutput = 1'b1;
    for (int k = 0; k < numPorts; k++)
    begin
      rrPort = (portW + k) % numPorts;
      hdrOrder.push_back(rrPort);
      sendPacket(rrPort, 2, 256 + 16 * k);
    end
    #10;
    holdOutput = 1'b0;
    waitDrain();

    testName = "backPressure";
    holdOutput = 1'b1;
    writeFlit(portN, headerFlit(queueDepth));
    for (int i = 0; i < queueDepth - 1; i++)
    begin
      writeFlit(portN, bodyFlit(512 + i));
    end
    fork
      writeFlit(portN, bodyFlit(512 + queueDepth - 1));
      begin
        repeat (5) @(posedge clk);
        #20;
        assert (inCyc && !inAck)
          else reportFailure("Write to a full queue was acknowledged");
        holdOutput = 1'b0;
      end
    join
    waitDrain();

    testName = "outOfRange";
    writeFlit(6, 16'hE5A5);   // Id 7, never used by real flits.
    sendPacket(portW, 1, 1024);
    waitDrain();

    if (flitRouter_inst.flitRouter_assert_inst.failCount == 0)
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
    else
    begin
      reportFailure("A bus assertion on the DUT ports failed");
    end
  end

endmodule

`default_nettype wire

//--- flitRouter_assert.sv
`timescale 1ns/100ps
`default_nettype none

module flitRouter_assert (
  input logic                               clk,
  input logic                               rst,
  input logic                               inAck,
  input logic                               outCyc,
  input logic                               outStb,
  input logic                               outAck,
  input logic [routerPkg::portAdrWidth-1:0] outAdr,
  input flitPkg::flitT                      outDat
);

  int unsigned failCount = 0;   // Watched by the testbench.

  stbInCyc: assert property (@(posedge clk) disable iff (rst) outStb |-> outCyc)
    else
    begin
      failCount++;
      $error("outStb high outside a bus cycle");
    end

  // Master holds the transfer until ack.
  stableUntilAck: assert property (@(posedge clk) disable iff (rst)
      (outStb && !outAck) |=> (outStb && $stable(outDat) && $stable(outAdr)))
    else
    begin
      failCount++;
      $error("Output transfer changed before ack");
    end

  idleAfterReset: assert property (@(posedge clk) rst |=> (!inAck && !outCyc && !outStb))
    else
    begin
      failCount++;
      $error("Bus control outputs active after reset");
    end

endmodule

bind flitRouter flitRouter_assert flitRouter_assert_inst (
  .clk    (clk),
  .rst    (rst),
  .inAck  (inAck),
  .outCyc (outCyc),
  .outStb (outStb),
  .outAck (outAck),
  .outAdr (outAdr),
  .outDat (outDat)
);

`default_nettype wire

//--- flitRouter.sv
`timescale 1ns/100ps
`default_nettype none

module flitRouter (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               inCyc,
  input  logic                               inStb,
  input  logic                               inWe,
  input  logic [routerPkg::portAdrWidth-1:0] inAdr,
  input  flitPkg::flitT                      inDat,
  output logic                               inAck,
  output logic                               outCyc,
  output logic                               outStb,
  output logic                               outWe,
  output logic [routerPkg::portAdrWidth-1:0] outAdr,
  output flitPkg::flitT                      outDat,
  input  logic                               outAck
);

  import flitPkg::*;
  import routerPkg::*;

  logic [numPorts-1:0] push;
  logic [numPorts-1:0] full;
  logic [numPorts-1:0] req;
  logic [numPorts-1:0] pop;
  logic [numPorts-1:0] grant;
  flitT pushData;
  flitT headFlit [numPorts];
  logic busy;
  logic flitSent;

  flitLoader flitLoader_inst (
    .clk      (clk),
    .rst      (rst),
    .inCyc    (inCyc),
    .inStb    (inStb),
    .inWe     (inWe),
    .inAdr    (inAdr),
    .inDat    (inDat),
    .full     (full),
    .inAck    (inAck),
    .push     (push),
    .pushData (pushData)
  );

  // One queue per port, L N E W S.
  for (genvar p = 0; p < numPorts; p++)
  begin : genQueue
    flitQueue flitQueue_inst (
      .clk      (clk),
      .rst      (rst),
      .push     (push[p]),
      .pushData (pushData),
      .pop      (pop[p]),
      .full     (full[p]),
      .req      (req[p]),
      .headFlit (headFlit[p])
    );
  end

  portArbiter portArbiter_inst (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .headFlit (headFlit),
    .busy     (busy),
    .flitSent (flitSent),
    .grant    (grant)
  );

  flitSender flitSender_inst (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (req),
    .headFlit (headFlit),
    .outAck   (outAck),
    .outCyc   (outCyc),
    .outStb   (outStb),
    .outWe    (outWe),
    .outAdr   (outAdr),
    .outDat   (outDat),
    .pop      (pop),
    .busy     (busy),
    .flitSent (flitSent)
  );

endmodule

`default_nettype wire

//--- flitSender.sv
`timescale 1ns/100ps
`default_nettype none

module flitSender (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [routerPkg::numPorts-1:0]     grant,
  input  logic [routerPkg::numPorts-1:0]     req,
  input  flitPkg::flitT                      headFlit [routerPkg::numPorts],
  input  logic                               outAck,
  output logic                               outCyc,
  output logic                               outStb,
  output logic                               outWe,
  output logic [routerPkg::portAdrWidth-1:0] outAdr,
  output flitPkg::flitT                      outDat,
  output logic [routerPkg::numPorts-1:0]     pop,
  output logic                               busy,
  output logic                               flitSent
);

  import routerPkg::*;

  logic active;   // Transfer in progress.
  logic gap;      // Idle cycle after an ack.
  logic start;
  logic [portAdrWidth-1:0] grantIdx;

  assign grantIdx = oneHotIndex(grant);
  assign start = ~active & ~gap & ((grant & req) != '0);

  // Low in the gap, so the arbiter sees the popped queue and updated timer.
  assign busy = active | start;
  assign flitSent = active & outAck;
  assign pop = grant & {numPorts{flitSent}};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active <= 1'b0;
      gap <= 1'b0;
    end
    else
    begin
      if (start)
      begin
        active <= 1'b1;
      end
      else if (flitSent)
      begin
        active <= 1'b0;
      end
      gap <= flitSent;
    end
  end

  // Held until ack.
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      outDat <= headFlit[grantIdx];
      outAdr <= grantIdx;
    end
  end

  assign outCyc = active;
  assign outStb = active;
  assign outWe = 1'b1;   // Write only.

endmodule

`default_nettype wire

//--- portArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module portArbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [routerPkg::numPorts-1:0] req,
  input  flitPkg::flitT                  headFlit [routerPkg::numPorts],
  input  logic                           busy,
  input  logic                           flitSent,
  output logic [routerPkg::numPorts-1:0] grant
);

  import flitPkg::*;
  import routerPkg::*;

  logic [portAdrWidth-1:0] curIdx;
  flitT sentFlit;
  logic isHeader;
  logic [numPorts-1:0] timerLoad;
  logic [numPorts-1:0] timerCount;
  logic [numPorts-1:0] done;
  logic [numPorts-1:0] nextGrant;

  // With no grant the search starts after S, so L goes first.
  assign curIdx = (grant == '0) ? portAdrWidth'(portS) : oneHotIndex(grant);

  // Head of the granted queue is the flit on the bus until the pop.
  assign sentFlit = headFlit[curIdx];
  assign isHeader = sentFlit.hdr.id == idHeader;

  assign timerLoad = grant & {numPorts{flitSent & isHeader}};
  assign timerCount = grant & {numPorts{flitSent & ~isHeader}};

  for (genvar p = 0; p < numPorts; p++)
  begin : genTimer
    packetTimer packetTimer_inst (
      .clk    (clk),
      .rst    (rst),
      .load   (timerLoad[p]),
      .length (sentFlit.hdr.length),
      .count  (timerCount[p]),
      .done   (done[p])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hold or rotate
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    logic found;
    int idx;
    found = 1'b0;
    idx = 0;
    nextGrant = grant;   // Kept when nobody requests.
    if ((grant & req & ~done) == '0)
    begin
      for (int step = 1; step <= numPorts; step++)
      begin
        idx = (curIdx + step) % numPorts;
        if (!found && req[idx])
        begin
          nextGrant = '0;
          nextGrant[idx] = 1'b1;
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
    end
    else if (!busy)
    begin
      grant <= nextGrant;
    end
  end

endmodule

`default_nettype wire

//--- packetTimer.sv
`timescale 1ns/100ps
`default_nettype none

module packetTimer (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            load,
  input  logic [flitPkg::lengthWidth-1:0] length,
  input  logic                            count,
  output logic                            done
);

  import flitPkg::*;

  logic [lengthWidth-1:0] target;
  logic [lengthWidth-1:0] flitCount;

  // Counts body flits sent, so a stalled output never ends a packet.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      target <= '0;
      flitCount <= '0;
    end
    else if (load)
    begin
      target <= length;
      flitCount <= '0;
    end
    else if (count)
    begin
      flitCount <= flitCount + 1'b1;
    end
  end

  assign done = flitCount == target;   // Idle timers read as done.

endmodule

`default_nettype wire

//--- flitQueue.sv
`timescale 1ns/100ps
`default_nettype none

module flitQueue (
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  flitPkg::flitT pushData,
  input  logic          pop,
  output logic          full,
  output logic          req,
  output flitPkg::flitT headFlit
);

  import flitPkg::*;
  import routerPkg::*;

  flitT mem [queueDepth];
  logic [queuePtrWidth-1:0] wrPtr;
  logic [queuePtrWidth-1:0] rdPtr;
  logic [queuePtrWidth:0] count;
  logic doPush;
  logic doPop;

  assign full = count == queueDepth;
  assign req = count != '0;
  assign headFlit = mem[rdPtr];

  assign doPush = push & ~full;
  assign doPop = pop & req;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      mem[wrPtr] <= pushData;
    end
  end

  // Pointers wrap on their own width.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Both or neither.
      endcase
    end
  end

endmodule

`default_nettype wire

//--- flitLoader.sv
`timescale 1ns/100ps
`default_nettype none

module flitLoader (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                inCyc,
  input  logic                                inStb,
  input  logic                                inWe,
  input  logic [routerPkg::portAdrWidth-1:0]  inAdr,
  input  flitPkg::flitT                       inDat,
  input  logic [routerPkg::numPorts-1:0]      full,
  output logic                                inAck,
  output logic [routerPkg::numPorts-1:0]      push,
  output flitPkg::flitT                       pushData
);

  import routerPkg::*;

  logic inRange;
  logic targetFull;
  logic accept;

  assign inRange = inAdr < numPorts;   // Others are acked and dropped.

  always_comb
  begin
    targetFull = 1'b0;
    if (inRange)
    begin
      targetFull = full[inAdr];
    end
  end

  // No new accept during the ack cycle.
  assign accept = inCyc & inStb & ~inAck & ~(inWe & inRange & targetFull);

  always_comb
  begin
    push = '0;
    if (accept && inWe && inRange)
    begin
      push[inAdr] = 1'b1;
    end
  end

  assign pushData = inDat;   // Shared by all queues.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck <= 1'b0;
    end
    else
    begin
      inAck <= accept;
    end
  end

endmodule

`default_nettype wire

//--- routerPkg.sv
`default_nettype none

package routerPkg;

  localparam int numPorts = 5;

  // Port indices, also the round-robin order.
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  localparam int queueDepth = 8;
  localparam int queuePtrWidth = $clog2(queueDepth);
  localparam int portAdrWidth = 3;

  // Index of the set bit in a one-hot port vector.
  function automatic logic [portAdrWidth-1:0] oneHotIndex(input logic [numPorts-1:0] oneHot);
    logic [portAdrWidth-1:0] idx;
    idx = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (oneHot[i])
      begin
        idx = portAdrWidth'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

//--- flitPkg.sv
`default_nettype none

package flitPkg;

  localparam int flitWidth = 16;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12;

  // Flit id codes.
  localparam logic [flitIdWidth-1:0] idHeader = 3'd1;
  localparam logic [flitIdWidth-1:0] idBody = 3'd2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One flit word, two views
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef union packed {
    struct packed {
      logic [flitIdWidth-1:0] id;
      logic [lengthWidth-1:0] length;   // Body flits that follow.
      logic [flitWidth-flitIdWidth-lengthWidth-1:0] spare;
    } hdr;
    struct packed {
      logic [flitIdWidth-1:0] id;
      logic [flitWidth-flitIdWidth-1:0] payload;
    } body;
  } flitT;

endpackage

`default_nettype wire
